//--- logic/vdp_cfg.svh
//--------------------------------------------------------------------
// Widths and register bit positions for the VDP CPU port.
// Include this wherever a width or a control register bit is needed.
//--------------------------------------------------------------------
`ifndef VDP_CFG_SVH
`define VDP_CFG_SVH

// Data byte on the CPU bus and on the VRAM bus
`define VDP_DATA_W 8

// VRAM address, 16K bytes
`define VDP_ADDR_W 14

// Control register number carried in the low bits of the second byte
`define VDP_REG_IDX_W 3

// Fifth-sprite number in the status byte
`define VDP_SPR_NUM_W 5

// Register 0 bits
`define VDP_R0_M3_BIT 1

// Register 1 bits
// Display enable, inverted to form blanking
`define VDP_R1_DISP_BIT 6
// Interrupt enable
`define VDP_R1_IE_BIT 5
`define VDP_R1_M1_BIT 4
`define VDP_R1_M2_BIT 3

`endif

//--- logic/vdp_pkg.sv
//--------------------------------------------------------------------
// Shared types of the VDP CPU port.
// Referenced by scoped name from every block of the port.
//--------------------------------------------------------------------
`include "vdp_cfg.svh"

package vdp_pkg;

  // Plain vectors for widths with a meaning
  typedef logic [`VDP_DATA_W-1:0]    cpu_data_t;
  typedef logic [`VDP_ADDR_W-1:0]    vram_addr_t;
  typedef logic [`VDP_REG_IDX_W-1:0] reg_idx_t;
  typedef logic [`VDP_SPR_NUM_W-1:0] spr_num_t;

  // Owner of the current VRAM access slot
  // Driven by the external video timing logic
  typedef enum logic [1:0]
  {
    AC_NONE  = 2'd0,
    AC_VIDEO = 2'd1,
    AC_CPU   = 2'd2
  } access_t;

  // Display modes decoded from M1, M2 and M3
  typedef enum logic [1:0]
  {
    OPMODE_GRAPH1 = 2'd0,
    OPMODE_GRAPH2 = 2'd1,
    OPMODE_MULTIC = 2'd2,
    OPMODE_TEXTM  = 2'd3
  } opmode_t;

endpackage

//--- logic/cpu_port_sequencer.sv
//--------------------------------------------------------------------
// CPU strobe decoder and access FSM of the VDP port.
// Turns rd/wr/mode strobes into one-cycle buffer and register
// commands, level ones while a strobe is held, completion ones
// in the cycle after the strobe drops.
//--------------------------------------------------------------------
`include "vdp_cfg.svh"

module cpu_port_sequencer
(
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                rd_i,
  input  logic                wr_i,
  input  logic                mode_i,
  input  vdp_pkg::cpu_data_t  cd_sel_i,
  output logic                cpu_wr_buf_o,
  output logic                sched_read_o,
  output logic                sched_write_o,
  output logic                load_addr_o,
  output logic                tmp_wr_o,
  output logic                reg_wr_o,
  output logic                status_rd_done_o,
  output logic                rd_data_sel_o
);

  // Kind of access seen on the bus in this cycle
  typedef enum logic [2:0]
  {
    XF_NONE,
    XF_RD_DATA,
    XF_WR_DATA,
    XF_RD_STATUS,
    XF_WR_CTRL
  } xfer_t;

  typedef enum logic [3:0]
  {
    ST_IDLE,
    ST_RD_DATA,
    ST_WR_DATA,
    ST_RD_STATUS,
    ST_WR_CTRL1,
    // First control byte done, pair still open
    ST_WAIT_CTRL2,
    ST_CTRL2_VREAD,
    ST_CTRL2_VWRITE,
    ST_CTRL2_REG
  } state_t;

  xfer_t  xfer;
  state_t state_q;
  state_t state_d;
  // State the current access belongs to, including its first cycle
  state_t state_cur;

  // ------------------------------------------------------------------
  // Bus decode
  // ------------------------------------------------------------------
  always_comb
  begin
    xfer = XF_NONE;
    if (rd_i)
      xfer = mode_i ? XF_RD_STATUS : XF_RD_DATA;
    // A write strobe wins over a read
    if (wr_i)
      xfer = mode_i ? XF_WR_CTRL : XF_WR_DATA;
  end

  // ------------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE, ST_WAIT_CTRL2:
      begin
        case (xfer)
          XF_RD_DATA:   state_d = ST_RD_DATA;
          XF_WR_DATA:   state_d = ST_WR_DATA;
          XF_RD_STATUS: state_d = ST_RD_STATUS;
          XF_WR_CTRL:
          begin
            // Second byte of a pair when a first byte is waiting
            if (state_q == ST_IDLE)
              state_d = ST_WR_CTRL1;
            else if (cd_sel_i[7])
              state_d = ST_CTRL2_REG;
            else if (cd_sel_i[6])
              state_d = ST_CTRL2_VWRITE;
            else
              state_d = ST_CTRL2_VREAD;
          end
          default: state_d = state_q;
        endcase
      end
      ST_WR_CTRL1:
      begin
        if (xfer == XF_NONE)
          state_d = ST_WAIT_CTRL2;
      end
      default:
      begin
        // Any other access state ends when the strobe drops
        if (xfer == XF_NONE)
          state_d = ST_IDLE;
      end
    endcase
  end

  // Idle states hand over to the new access in the same cycle
  assign state_cur = ((state_q == ST_IDLE) || (state_q == ST_WAIT_CTRL2)) ? state_d : state_q;

  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  // ------------------------------------------------------------------
  // Commands
  // ------------------------------------------------------------------
  // Level commands, only while cd_i is valid under the strobe
  assign cpu_wr_buf_o = (xfer != XF_NONE) && (state_cur == ST_WR_DATA);
  assign tmp_wr_o     = (xfer != XF_NONE) && (state_cur == ST_WR_CTRL1);
  assign load_addr_o  = (xfer != XF_NONE) &&
                        ((state_cur == ST_CTRL2_VREAD) || (state_cur == ST_CTRL2_VWRITE));
  assign reg_wr_o     = (xfer != XF_NONE) && (state_cur == ST_CTRL2_REG);

  // Completion commands in the cycle after release
  assign sched_read_o     = (xfer == XF_NONE) &&
                            ((state_q == ST_RD_DATA) || (state_q == ST_CTRL2_VREAD));
  assign sched_write_o    = (xfer == XF_NONE) && (state_q == ST_WR_DATA);
  assign status_rd_done_o = (xfer == XF_NONE) && (state_q == ST_RD_STATUS);

  // Buffer on cd_o for the whole data read, status otherwise
  assign rd_data_sel_o = (state_cur == ST_RD_DATA);

endmodule

//--- logic/vram_access_buffer.sv
//--------------------------------------------------------------------
// Shared read-ahead / write-back byte and VRAM address counter.
// Scheduled requests wait for the next slot, then for a CPU slot,
// where the byte is read from or written to VRAM.
//--------------------------------------------------------------------
`include "vdp_cfg.svh"

module vram_access_buffer
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 clk_en_acc_i,
  input  vdp_pkg::access_t     access_type_i,
  input  logic                 cpu_wr_buf_i,
  input  logic                 sched_read_i,
  input  logic                 sched_write_i,
  input  logic                 load_addr_i,
  input  vdp_pkg::cpu_data_t   cd_i,
  input  vdp_pkg::cpu_data_t   tmp_i,
  input  vdp_pkg::cpu_data_t   vram_d_i,
  output logic                 vram_we_o,
  output vdp_pkg::vram_addr_t  vram_a_o,
  output vdp_pkg::cpu_data_t   buf_o
);

  vdp_pkg::cpu_data_t  buf_q;
  vdp_pkg::vram_addr_t addr_q;

  // Scheduled, waiting for slot phase
  logic rd_pend_q;
  logic wr_pend_q;
  // Aligned, scanning for a CPU slot
  logic rd_act_q;
  logic wr_act_q;

  logic cpu_slot;
  logic rd_serve;
  logic wr_serve;
  logic incr_addr;

  // ------------------------------------------------------------------
  // Slot decode
  // ------------------------------------------------------------------
  assign cpu_slot = (access_type_i == vdp_pkg::AC_CPU);

  // Write strobe spans the whole CPU slot, commit on the enable
  assign vram_we_o = wr_act_q && cpu_slot;
  assign wr_serve  = vram_we_o && clk_en_acc_i;

  // A CPU data write in the same cycle drops the read-ahead
  assign rd_serve  = rd_act_q && cpu_slot && clk_en_acc_i && !cpu_wr_buf_i;

  assign incr_addr = wr_serve || rd_serve;

  // ------------------------------------------------------------------
  // Request flags
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      rd_pend_q <= 1'b0;
      rd_act_q  <= 1'b0;
      wr_pend_q <= 1'b0;
      wr_act_q  <= 1'b0;
    end
    else
    begin
      // Read-ahead
      if (cpu_wr_buf_i)
        rd_pend_q <= 1'b0;
      else if (sched_read_i)
        rd_pend_q <= 1'b1;
      else if (clk_en_acc_i)
        rd_pend_q <= 1'b0;

      if (cpu_wr_buf_i)
        rd_act_q <= 1'b0;
      else if (rd_pend_q && clk_en_acc_i)
        rd_act_q <= 1'b1;
      else if (rd_serve)
        rd_act_q <= 1'b0;

      // Write-back, cancelled by a new read
      if (sched_read_i)
        wr_pend_q <= 1'b0;
      else if (sched_write_i)
        wr_pend_q <= 1'b1;
      else if (clk_en_acc_i)
        wr_pend_q <= 1'b0;

      if (sched_read_i)
        wr_act_q <= 1'b0;
      else if (wr_pend_q && clk_en_acc_i)
        wr_act_q <= 1'b1;
      else if (wr_serve)
        wr_act_q <= 1'b0;
    end
  end

  // ------------------------------------------------------------------
  // Data byte and address
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      buf_q  <= '0;
      addr_q <= '0;
    end
    else
    begin
      if (cpu_wr_buf_i)
        buf_q <= cd_i;
      else if (rd_serve)
        buf_q <= vram_d_i;

      // High bits from the second byte, low byte from the first
      if (load_addr_i)
        addr_q <= {cd_i[`VDP_ADDR_W-`VDP_DATA_W-1:0], tmp_i};
      else if (incr_addr)
        addr_q <= addr_q + 1'b1;
    end
  end

  assign vram_a_o = addr_q;
  assign buf_o    = buf_q;

endmodule

//--- logic/vdp_register_file.sv
//--------------------------------------------------------------------
// Control registers 0, 1, 2 and 7, temporary byte and status flags.
// Decodes display mode, blanking, name table base and colours, and
// drives the interrupt line from the flag and the enable bit.
//--------------------------------------------------------------------
`include "vdp_cfg.svh"

module vdp_register_file
(
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                tmp_wr_i,
  input  logic                reg_wr_i,
  input  logic                status_rd_done_i,
  input  vdp_pkg::cpu_data_t  cd_i,
  input  logic                spr_coll_i,
  input  logic                spr_5th_i,
  input  vdp_pkg::spr_num_t   spr_5th_num_i,
  input  logic                irq_i,
  output vdp_pkg::cpu_data_t  tmp_o,
  output vdp_pkg::cpu_data_t  status_o,
  output vdp_pkg::opmode_t    opmode_o,
  output logic                reg_blank_o,
  output logic [3:0]          reg_ntb_o,
  output logic [3:0]          reg_col1_o,
  output logic [3:0]          reg_col0_o,
  output logic                int_n_o
);

  vdp_pkg::cpu_data_t tmp_q;
  vdp_pkg::cpu_data_t reg0_q;
  vdp_pkg::cpu_data_t reg1_q;
  vdp_pkg::cpu_data_t reg2_q;
  vdp_pkg::cpu_data_t reg7_q;
  vdp_pkg::reg_idx_t  reg_idx;

  logic               int_q;
  logic               spr_5th_q;
  logic               spr_coll_q;
  vdp_pkg::spr_num_t  spr_5th_num_q;

  // Register number from the second control byte
  assign reg_idx = cd_i[`VDP_REG_IDX_W-1:0];

  // ------------------------------------------------------------------
  // Temporary byte and control registers
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      tmp_q  <= '0;
      reg0_q <= '0;
      reg1_q <= '0;
      reg2_q <= '0;
      reg7_q <= '0;
    end
    else
    begin
      if (tmp_wr_i)
        tmp_q <= cd_i;
      if (reg_wr_i)
      begin
        case (reg_idx)
          3'd0:    reg0_q <= tmp_q;
          3'd1:    reg1_q <= tmp_q;
          3'd2:    reg2_q <= tmp_q;
          3'd7:    reg7_q <= tmp_q;
          // Registers 3 to 6 accepted, nothing stored
          default: ;
        endcase
      end
    end
  end

  // ------------------------------------------------------------------
  // Status flags, an event wins over the read clear
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      int_q         <= 1'b0;
      spr_5th_q     <= 1'b0;
      spr_coll_q    <= 1'b0;
      spr_5th_num_q <= '0;
    end
    else
    begin
      if (irq_i)
        int_q <= 1'b1;
      else if (status_rd_done_i)
        int_q <= 1'b0;

      if (spr_coll_i)
        spr_coll_q <= 1'b1;
      else if (status_rd_done_i)
        spr_coll_q <= 1'b0;

      if (spr_5th_i)
        spr_5th_q <= 1'b1;
      else if (status_rd_done_i)
        spr_5th_q <= 1'b0;

      // First fifth sprite since the last read keeps its number
      if (spr_5th_i && !spr_5th_q)
        spr_5th_num_q <= spr_5th_num_i;
    end
  end

  assign status_o = {int_q, spr_5th_q, spr_coll_q, spr_5th_num_q};

  // ------------------------------------------------------------------
  // Mode decode and output mapping
  // ------------------------------------------------------------------
  always_comb
  begin
    case ({reg1_q[`VDP_R1_M1_BIT], reg1_q[`VDP_R1_M2_BIT], reg0_q[`VDP_R0_M3_BIT]})
      3'b000:  opmode_o = vdp_pkg::OPMODE_GRAPH1;
      3'b001:  opmode_o = vdp_pkg::OPMODE_GRAPH2;
      3'b010:  opmode_o = vdp_pkg::OPMODE_MULTIC;
      default: opmode_o = vdp_pkg::OPMODE_TEXTM;
    endcase
  end

  assign tmp_o       = tmp_q;
  assign reg_blank_o = ~reg1_q[`VDP_R1_DISP_BIT];
  assign reg_ntb_o   = reg2_q[3:0];
  assign reg_col1_o  = reg7_q[7:4];
  assign reg_col0_o  = reg7_q[3:0];
  // Active low, only with the enable bit set
  assign int_n_o     = ~(int_q & reg1_q[`VDP_R1_IE_BIT]);

endmodule

//--- logic/vdp_cpuio.sv
//--------------------------------------------------------------------
// CPU port of the VDP, top level.
// Connects the strobe FSM, the VRAM access buffer and the register
// file, and selects the byte shown on the CPU data bus.
//--------------------------------------------------------------------
`include "vdp_cfg.svh"

module vdp_cpuio
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 rd_i,
  input  logic                 wr_i,
  input  logic                 mode_i,
  input  vdp_pkg::cpu_data_t   cd_i,
  input  logic                 clk_en_acc_i,
  input  vdp_pkg::access_t     access_type_i,
  input  vdp_pkg::cpu_data_t   vram_d_i,
  input  logic                 spr_coll_i,
  input  logic                 spr_5th_i,
  input  vdp_pkg::spr_num_t    spr_5th_num_i,
  input  logic                 irq_i,
  output vdp_pkg::cpu_data_t   cd_o,
  output logic                 cd_oe_o,
  output logic                 vram_we_o,
  output vdp_pkg::vram_addr_t  vram_a_o,
  output vdp_pkg::opmode_t     opmode_o,
  output logic                 reg_blank_o,
  output logic [3:0]           reg_ntb_o,
  output logic [3:0]           reg_col1_o,
  output logic [3:0]           reg_col0_o,
  output logic                 int_n_o
);

  // Sequencer commands
  logic cpu_wr_buf;
  logic sched_read;
  logic sched_write;
  logic load_addr;
  logic tmp_wr;
  logic reg_wr;
  logic status_rd_done;
  logic rd_data_sel;

  vdp_pkg::cpu_data_t tmp_byte;
  vdp_pkg::cpu_data_t status_byte;
  // Read-ahead / write-back byte, also the VRAM write data
  vdp_pkg::cpu_data_t buf_data;

  cpu_port_sequencer u_seq
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .rd_i             (rd_i),
    .wr_i             (wr_i),
    .mode_i           (mode_i),
    .cd_sel_i         (cd_i),
    .cpu_wr_buf_o     (cpu_wr_buf),
    .sched_read_o     (sched_read),
    .sched_write_o    (sched_write),
    .load_addr_o      (load_addr),
    .tmp_wr_o         (tmp_wr),
    .reg_wr_o         (reg_wr),
    .status_rd_done_o (status_rd_done),
    .rd_data_sel_o    (rd_data_sel)
  );

  vram_access_buffer u_buf
  (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .clk_en_acc_i  (clk_en_acc_i),
    .access_type_i (access_type_i),
    .cpu_wr_buf_i  (cpu_wr_buf),
    .sched_read_i  (sched_read),
    .sched_write_i (sched_write),
    .load_addr_i   (load_addr),
    .cd_i          (cd_i),
    .tmp_i         (tmp_byte),
    .vram_d_i      (vram_d_i),
    .vram_we_o     (vram_we_o),
    .vram_a_o      (vram_a_o),
    .buf_o         (buf_data)
  );

  vdp_register_file u_regs
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .tmp_wr_i         (tmp_wr),
    .reg_wr_i         (reg_wr),
    .status_rd_done_i (status_rd_done),
    .cd_i             (cd_i),
    .spr_coll_i       (spr_coll_i),
    .spr_5th_i        (spr_5th_i),
    .spr_5th_num_i    (spr_5th_num_i),
    .irq_i            (irq_i),
    .tmp_o            (tmp_byte),
    .status_o         (status_byte),
    .opmode_o         (opmode_o),
    .reg_blank_o      (reg_blank_o),
    .reg_ntb_o        (reg_ntb_o),
    .reg_col1_o       (reg_col1_o),
    .reg_col0_o       (reg_col0_o),
    .int_n_o          (int_n_o)
  );

  // Data read shows the buffer, anything else the status byte
  assign cd_o    = rd_data_sel ? buf_data : status_byte;
  assign cd_oe_o = rd_i;

endmodule

//--- verification/vdp_cpuio_tb_cases.svh
//--------------------------------------------------------------------
// Stimulus table of the CPU port testbench, applied in order.
// Columns are name, operation, operand a, operand b, expected value.
// CTRL expects {int_n, opmode, blank, ntb, col1, col0}, WDATA the
// commit address, RDATA the address read, STAT and EVENT {int_n, status}
//--------------------------------------------------------------------

task automatic fill_cases();
  // Register writes through all four display modes
  add_case("r7_colours",     OP_CTRL, 8'hF4, 8'h87, 16'h90F4);
  add_case("r2_name_table",  OP_CTRL, 8'h0E, 8'h82, 16'h9EF4);
  add_case("r0_m3_graph2",   OP_CTRL, 8'h02, 8'h80, 16'hBEF4);
  add_case("r1_m2_text",     OP_CTRL, 8'h48, 8'h81, 16'hEEF4);
  add_case("r0_multicolor",  OP_CTRL, 8'h00, 8'h80, 16'hCEF4);
  add_case("r1_m1_text",     OP_CTRL, 8'h10, 8'h81, 16'hFEF4);
  add_case("r1_graph1",      OP_CTRL, 8'h40, 8'h81, 16'h8EF4);
  // Register 4 has no storage
  add_case("r4_ignored",     OP_CTRL, 8'hFF, 8'h84, 16'h8EF4);

  // Write setup at 0x0100 followed by consecutive writes
  add_case("wsetup_0100",    OP_CTRL,  8'h00, 8'h41, 16'h8EF4);
  add_case("wdata_0100",     OP_WDATA, 8'hA5, 8'h00, 16'h0100);
  add_case("wdata_0101",     OP_WDATA, 8'h5A, 8'h00, 16'h0101);
  add_case("wdata_0102",     OP_WDATA, 8'hC3, 8'h00, 16'h0102);

  // Read setup at 0x1234 and read-ahead bytes in order
  add_case("rsetup_1234",    OP_CTRL,  8'h34, 8'h12, 16'h8EF4);
  add_case("rdata_1234",     OP_RDATA, 8'h00, 8'h00, 16'h1234);
  add_case("rdata_1235",     OP_RDATA, 8'h00, 8'h00, 16'h1235);
  add_case("rdata_1236",     OP_RDATA, 8'h00, 8'h00, 16'h1236);
  add_case("rdata_1237",     OP_RDATA, 8'h00, 8'h00, 16'h1237);

  // Collision and fifth sprite each set their own bit
  // Number held until the flag is read
  add_case("status_idle",    OP_STAT,  8'h00, 8'h00, 16'h0100);
  add_case("coll_only",      OP_EVENT, 8'h01, 8'h15, 16'h0120);
  add_case("fifth_first",    OP_EVENT, 8'h02, 8'h0B, 16'h016B);
  add_case("fifth_again",    OP_EVENT, 8'h02, 8'h1C, 16'h016B);
  add_case("status_flags",   OP_STAT,  8'h00, 8'h00, 16'h016B);
  add_case("status_cleared", OP_STAT,  8'h00, 8'h00, 16'h010B);

  // Interrupt with enable off, then on
  add_case("irq_ie_off",     OP_EVENT, 8'h04, 8'h00, 16'h018B);
  add_case("r1_ie_on",       OP_CTRL,  8'h60, 8'h81, 16'h0EF4);
  add_case("status_irq",     OP_STAT,  8'h00, 8'h00, 16'h008B);
  add_case("irq_released",   OP_EVENT, 8'h00, 8'h00, 16'h010B);
  add_case("irq_ie_on",      OP_EVENT, 8'h04, 8'h00, 16'h008B);
  add_case("status_irq_2",   OP_STAT,  8'h00, 8'h00, 16'h008B);
  add_case("irq_released_2", OP_EVENT, 8'h00, 8'h00, 16'h010B);
endtask

//--- verification/vdp_cpuio_tb.sv
//--------------------------------------------------------------------
// Testbench of the VDP CPU port.
// Drives CPU strobes from a table, models a 16K VRAM with random
// slot owners, and checks registers, VRAM writes, reads and status.
//--------------------------------------------------------------------
`include "vdp_cfg.svh"

module vdp_cpuio_tb;

  localparam int WAIT_LIMIT = 200;

  // Table operations
  localparam logic [2:0] OP_CTRL  = 3'd0;
  localparam logic [2:0] OP_WDATA = 3'd1;
  localparam logic [2:0] OP_RDATA = 3'd2;
  localparam logic [2:0] OP_STAT  = 3'd3;
  localparam logic [2:0] OP_EVENT = 3'd4;

  logic                clk_i;
  logic                reset_i       = 1'b1;
  logic                rd_i          = 1'b0;
  logic                wr_i          = 1'b0;
  logic                mode_i        = 1'b0;
  vdp_pkg::cpu_data_t  cd_i          = '0;
  logic                clk_en_acc_i  = 1'b0;
  vdp_pkg::access_t    access_type_i = vdp_pkg::AC_VIDEO;
  vdp_pkg::cpu_data_t  vram_d_i;
  logic                spr_coll_i    = 1'b0;
  logic                spr_5th_i     = 1'b0;
  vdp_pkg::spr_num_t   spr_5th_num_i = '0;
  logic                irq_i         = 1'b0;

  vdp_pkg::cpu_data_t  cd_o;
  logic                cd_oe_o;
  logic                vram_we_o;
  vdp_pkg::vram_addr_t vram_a_o;
  vdp_pkg::opmode_t    opmode_o;
  logic                reg_blank_o;
  logic [3:0]          reg_ntb_o;
  logic [3:0]          reg_col1_o;
  logic [3:0]          reg_col0_o;
  logic                int_n_o;

  // VRAM model and slot timing
  vdp_pkg::cpu_data_t  vram_mem [0:(1 << `VDP_ADDR_W) - 1];
  logic [1:0]          slot_cnt = 2'd0;
  logic [31:0]         lfsr_q   = 32'hdf57;

  // Case table
  string               case_name [$];
  logic [2:0]          case_op [$];
  logic [7:0]          case_a [$];
  logic [7:0]          case_b [$];
  logic [15:0]         case_exp [$];

  int                  value_errors   = 0;
  int                  timeout_errors = 0;

  vdp_cpuio uut
  (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .rd_i          (rd_i),
    .wr_i          (wr_i),
    .mode_i        (mode_i),
    .cd_i          (cd_i),
    .clk_en_acc_i  (clk_en_acc_i),
    .access_type_i (access_type_i),
    .vram_d_i      (vram_d_i),
    .spr_coll_i    (spr_coll_i),
    .spr_5th_i     (spr_5th_i),
    .spr_5th_num_i (spr_5th_num_i),
    .irq_i         (irq_i),
    .cd_o          (cd_o),
    .cd_oe_o       (cd_oe_o),
    .vram_we_o     (vram_we_o),
    .vram_a_o      (vram_a_o),
    .opmode_o      (opmode_o),
    .reg_blank_o   (reg_blank_o),
    .reg_ntb_o     (reg_ntb_o),
    .reg_col1_o    (reg_col1_o),
    .reg_col0_o    (reg_col0_o),
    .int_n_o       (int_n_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    lfsr_next = state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  // Every address bit reaches the byte
  function automatic vdp_pkg::cpu_data_t fill_byte(input vdp_pkg::vram_addr_t addr);
    fill_byte = addr[7:0] ^ {addr[13:8], addr[13:12]};
  endfunction

  // ------------------------------------------------------------------
  // VRAM model
  // ------------------------------------------------------------------
  assign vram_d_i = vram_mem[vram_a_o];

  // Write data is the buffer byte inside the port
  always @(posedge clk_i)
  begin
    if (vram_we_o && clk_en_acc_i)
      vram_mem[vram_a_o] <= uut.buf_data;
  end

  // Slot enable every fourth cycle, owner drawn once per slot
  always @(posedge clk_i)
  begin
    slot_cnt <= slot_cnt + 2'd1;
    clk_en_acc_i <= (slot_cnt == 2'd2);
    if (slot_cnt == 2'd3)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      access_type_i <= lfsr_q[0] ? vdp_pkg::AC_CPU : vdp_pkg::AC_VIDEO;
    end
  end

  // ------------------------------------------------------------------
  // Tasks
  // ------------------------------------------------------------------
  task automatic add_case(input string name, input logic [2:0] op, input logic [7:0] a,
                          input logic [7:0] b, input logic [15:0] exp);
    case_name.push_back(name);
    case_op.push_back(op);
    case_a.push_back(a);
    case_b.push_back(b);
    case_exp.push_back(exp);
  endtask

  `include "vdp_cpuio_tb_cases.svh"

  task automatic report_mismatch(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
    $display("error %s: expected %h, actual %h", name, exp, act);
    value_errors++;
  endtask

  // Strobe for two cycles, then release and let the access complete
  task automatic bus_access(input string name, input logic is_rd, input logic is_ctrl,
                            input logic [7:0] data, output logic [7:0] seen,
                            output logic seen_int_n);
    @(posedge clk_i);
    rd_i   <= is_rd;
    wr_i   <= ~is_rd;
    mode_i <= is_ctrl;
    cd_i   <= data;
    @(negedge clk_i);
    if (cd_oe_o !== is_rd)
      report_mismatch({name, " cd_oe"}, {15'd0, is_rd}, {15'd0, cd_oe_o});
    @(negedge clk_i);
    if (cd_oe_o !== is_rd)
      report_mismatch({name, " cd_oe"}, {15'd0, is_rd}, {15'd0, cd_oe_o});
    seen       = cd_o;
    seen_int_n = int_n_o;
    @(posedge clk_i);
    rd_i <= 1'b0;
    wr_i <= 1'b0;
    @(negedge clk_i);
    if (cd_oe_o !== 1'b0)
      report_mismatch({name, " cd_oe"}, 16'd0, {15'd0, cd_oe_o});
    // Completion edge
    @(posedge clk_i);
  endtask

  task automatic wait_write_commit(input string name, output vdp_pkg::vram_addr_t addr);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    addr = '0;
    while (!done && n < WAIT_LIMIT)
    begin
      @(negedge clk_i);
      if (vram_we_o && clk_en_acc_i)
      begin
        done = 1'b1;
        addr = vram_a_o;
      end
      n++;
    end
    if (!done)
    begin
      $display("timeout in %s: no VRAM write within %0d cycles", name, WAIT_LIMIT);
      timeout_errors++;
    end
    else
      @(negedge clk_i);
  endtask

  // A served read-ahead moves the address on
  task automatic wait_read_ahead(input string name);
    int                  n;
    vdp_pkg::vram_addr_t start;
    n = 0;
    @(negedge clk_i);
    start = vram_a_o;
    while ((vram_a_o == start) && n < WAIT_LIMIT)
    begin
      @(negedge clk_i);
      n++;
    end
    if (vram_a_o == start)
    begin
      $display("timeout in %s: read-ahead did not finish in %0d cycles", name, WAIT_LIMIT);
      timeout_errors++;
    end
  endtask

  task automatic pulse_events(input logic irq, input logic fifth, input logic coll,
                              input vdp_pkg::spr_num_t num);
    @(posedge clk_i);
    irq_i         <= irq;
    spr_5th_i     <= fifth;
    spr_coll_i    <= coll;
    spr_5th_num_i <= num;
    @(posedge clk_i);
    irq_i      <= 1'b0;
    spr_5th_i  <= 1'b0;
    spr_coll_i <= 1'b0;
  endtask

  task automatic run_case(input int k);
    logic [7:0]          seen;
    logic                seen_int_n;
    logic [15:0]         actual;
    vdp_pkg::vram_addr_t addr;
    case (case_op[k])
      OP_CTRL:
      begin
        bus_access(case_name[k], 1'b0, 1'b1, case_a[k], seen, seen_int_n);
        bus_access(case_name[k], 1'b0, 1'b1, case_b[k], seen, seen_int_n);
        // Top bits 00 start a read-ahead at the new address
        if (case_b[k][7:6] == 2'b00)
          wait_read_ahead(case_name[k]);
        @(negedge clk_i);
        actual = {int_n_o, opmode_o, reg_blank_o, reg_ntb_o, reg_col1_o, reg_col0_o};
        if (actual !== case_exp[k])
          report_mismatch(case_name[k], case_exp[k], actual);
      end
      OP_WDATA:
      begin
        bus_access(case_name[k], 1'b0, 1'b0, case_a[k], seen, seen_int_n);
        wait_write_commit(case_name[k], addr);
        if ({2'b00, addr} !== case_exp[k])
          report_mismatch(case_name[k], case_exp[k], {2'b00, addr});
        if (vram_mem[case_exp[k][13:0]] !== case_a[k])
          report_mismatch(case_name[k], {8'h00, case_a[k]},
                          {8'h00, vram_mem[case_exp[k][13:0]]});
      end
      OP_RDATA:
      begin
        bus_access(case_name[k], 1'b1, 1'b0, 8'h00, seen, seen_int_n);
        if (seen !== fill_byte(case_exp[k][13:0]))
          report_mismatch(case_name[k], {8'h00, fill_byte(case_exp[k][13:0])}, {8'h00, seen});
        wait_read_ahead(case_name[k]);
      end
      OP_STAT:
      begin
        bus_access(case_name[k], 1'b1, 1'b1, 8'h00, seen, seen_int_n);
        actual = {7'd0, seen_int_n, seen};
        if (actual !== case_exp[k])
          report_mismatch(case_name[k], case_exp[k], actual);
      end
      default:
      begin
        // Operand a is irq, fifth sprite, collision from bit 2 down
        pulse_events(case_a[k][2], case_a[k][1], case_a[k][0], case_b[k][4:0]);
        @(negedge clk_i);
        actual = {7'd0, int_n_o, cd_o};
        if (actual !== case_exp[k])
          report_mismatch(case_name[k], case_exp[k], actual);
      end
    endcase
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial
  begin
    int idx;
    for (idx = 0; idx < (1 << `VDP_ADDR_W); idx++)
      vram_mem[idx] = fill_byte(idx[13:0]);
    fill_cases();
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    for (int k = 0; k < case_name.size(); k++)
      run_case(k);
    $display("Checks done, %0d value errors, %0d timeouts", value_errors, timeout_errors);
    if ((value_errors == 0) && (timeout_errors == 0))
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+logic
+incdir+verification
logic/vdp_pkg.sv
logic/cpu_port_sequencer.sv
logic/vram_access_buffer.sv
logic/vdp_register_file.sv
logic/vdp_cpuio.sv
verification/vdp_cpuio_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CPU port testbench with Verilator, then check the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module vdp_cpuio_tb -f verilog.f -Mdir obj_dir \
  && ./obj_dir/Vvdp_cpuio_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
